/* common/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

`define CACHE_OFFSET_BITS 5 // 32-byte lines.
`define CACHE_INDEX_BITS 3
`define CACHE_SETS 8
`define CACHE_TAG_BITS 24 // rest of the 32-bit address.

`endif

/* common/rv32i_types_pkg.sv */
package rv32i_types_pkg;

typedef logic [31:0] rv32i_word; // data word of a load or store.
typedef logic [31:0] rv32i_addr; // byte address.
typedef logic [3:0] byte_mask; // one enable per byte of a word.

endpackage : rv32i_types_pkg

/* common/cache_types_pkg.sv */
`include "cache_cfg.svh"

package cache_types_pkg;

typedef logic [8*(1 << `CACHE_OFFSET_BITS)-1:0] cache_line;
typedef logic [(1 << `CACHE_OFFSET_BITS)-1:0] line_mask; // one bit per byte of a line.
typedef logic [`CACHE_TAG_BITS-1:0] cache_tag;
typedef logic [`CACHE_INDEX_BITS-1:0] cache_index;
typedef logic [`CACHE_OFFSET_BITS-3:0] word_offset; // word within a line.

typedef enum logic [1:0] {
	dc_idle,
	dc_lookup,
	dc_writeback,
	dc_fill
} dcache_state;

typedef enum logic [1:0] {
	ic_idle,
	ic_lookup,
	ic_fill
} icache_state;

endpackage : cache_types_pkg

/* dcache/dcache_datapath.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module dcache_datapath
	import rv32i_types_pkg::*, cache_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input rv32i_addr data_addr,
	input rv32i_word data_wdata,
	input byte_mask data_byte_enable,
	input logic data_read,
	input logic data_write,
	input logic load_stage,
	input logic load_data,
	input logic load_tag,
	input logic set_valid,
	input logic set_dirty,
	input logic clear_dirty,
	input logic load_lru,
	input logic addr_sel_way,
	input cache_line dc_pmem_rdata,
	output rv32i_word data_rdata,
	output logic hit,
	output logic hit_way,
	output logic lru_way,
	output logic victim_dirty,
	output rv32i_addr dc_pmem_addr,
	output cache_line dc_pmem_wdata
);

cache_line data_arr [2][`CACHE_SETS];
cache_tag tag_arr [2][`CACHE_SETS];
logic [`CACHE_SETS-1:0] valid_arr [2];
logic [`CACHE_SETS-1:0] dirty_arr [2];
logic [`CACHE_SETS-1:0] lru_arr;

rv32i_addr stage_addr;
rv32i_word stage_wdata;
byte_mask stage_be;
logic stage_read;
logic stage_write;

cache_index idx;
cache_tag stage_tag;
word_offset offset;
logic [1:0] way_match;
cache_line hit_line;
cache_line write_line;
line_mask write_mask;
logic write_en;

assign idx = stage_addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
assign stage_tag = stage_addr[31 -: `CACHE_TAG_BITS];
assign offset = stage_addr[`CACHE_OFFSET_BITS-1:2];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		stage_read <= 1'b0;
		stage_write <= 1'b0;
	end else if (load_stage) begin
		stage_read <= data_read;
		stage_write <= data_write;
	end
end

always_ff @(posedge clk) begin
	if (load_stage) begin
		stage_addr <= data_addr;
		stage_wdata <= data_wdata;
		stage_be <= data_byte_enable;
	end
end

always_comb begin
	for (int w = 0; w < 2; w++) begin
		way_match[w] = valid_arr[w][idx] && (tag_arr[w][idx] == stage_tag);
	end
end

assign hit = (|way_match) && (stage_read || stage_write);
assign hit_way = way_match[1];
assign hit_line = data_arr[hit_way][idx];
assign data_rdata = hit_line[32*offset +: 32];

assign lru_way = lru_arr[idx];
assign victim_dirty = valid_arr[lru_way][idx] && dirty_arr[lru_way][idx];

// dirty victim goes out first, its bit is cleared before the fill.
assign dc_pmem_addr = victim_dirty ?
	{tag_arr[addr_sel_way][idx], idx, {`CACHE_OFFSET_BITS{1'b0}}} :
	{stage_tag, idx, {`CACHE_OFFSET_BITS{1'b0}}};
assign dc_pmem_wdata = data_arr[addr_sel_way][idx];

// bus adapter.
always_comb begin
	if (set_valid) begin
		write_line = dc_pmem_rdata; // fill takes the whole line.
		write_mask = '1;
	end else begin
		write_line = {8{stage_wdata}};
		write_mask = line_mask'(stage_be) << {offset, 2'b00};
	end
end

assign write_en = load_data && (set_valid || stage_write);

always_ff @(posedge clk) begin
	if (write_en) begin
		for (int b = 0; b < $bits(line_mask); b++) begin
			if (write_mask[b]) begin
				data_arr[addr_sel_way][idx][8*b +: 8] <= write_line[8*b +: 8];
			end
		end
	end
	if (load_tag) begin
		tag_arr[addr_sel_way][idx] <= stage_tag;
	end
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		valid_arr <= '{default: '0};
		dirty_arr <= '{default: '0};
		lru_arr <= '0;
	end else begin
		if (set_valid) begin
			valid_arr[addr_sel_way][idx] <= 1'b1;
		end
		if (set_dirty && stage_write) begin
			dirty_arr[addr_sel_way][idx] <= 1'b1; // store hit.
		end else if (clear_dirty) begin
			dirty_arr[addr_sel_way][idx] <= 1'b0;
		end
		if (load_lru) begin
			lru_arr[idx] <= ~addr_sel_way; // point at the other way.
		end
	end
end

endmodule : dcache_datapath

/* dcache/dcache_control.sv */
`timescale 1ns/1ns

module dcache_control
	import cache_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic data_read,
	input logic data_write,
	input logic hit,
	input logic hit_way,
	input logic lru_way,
	input logic victim_dirty,
	input logic dc_pmem_resp,
	output logic data_resp,
	output logic load_stage,
	output logic load_data,
	output logic load_tag,
	output logic set_valid,
	output logic set_dirty,
	output logic clear_dirty,
	output logic load_lru,
	output logic addr_sel_way,
	output logic dc_pmem_read,
	output logic dc_pmem_write
);

dcache_state state_q;
dcache_state state_d;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state_q <= dc_idle;
	end else begin
		state_q <= state_d;
	end
end

always_comb begin
	state_d = state_q;
	data_resp = 1'b0;
	load_stage = 1'b0;
	load_data = 1'b0;
	load_tag = 1'b0;
	set_valid = 1'b0;
	set_dirty = 1'b0;
	clear_dirty = 1'b0;
	load_lru = 1'b0;
	addr_sel_way = lru_way;
	dc_pmem_read = 1'b0;
	dc_pmem_write = 1'b0;
	unique case (state_q)
		dc_idle: begin
			if (data_read || data_write) begin
				load_stage = 1'b1;
				state_d = dc_lookup;
			end
		end
		dc_lookup: begin
			addr_sel_way = hit_way;
			if (hit) begin
				data_resp = 1'b1;
				load_data = 1'b1; // only a store writes.
				set_dirty = 1'b1;
				load_lru = 1'b1;
				load_stage = 1'b1; // take the next request now.
				state_d = (data_read || data_write) ? dc_lookup : dc_idle;
			end else begin
				state_d = victim_dirty ? dc_writeback : dc_fill;
			end
		end
		dc_writeback: begin
			dc_pmem_write = 1'b1;
			if (dc_pmem_resp) begin
				clear_dirty = 1'b1;
				state_d = dc_fill;
			end
		end
		dc_fill: begin
			dc_pmem_read = 1'b1;
			if (dc_pmem_resp) begin
				load_data = 1'b1;
				load_tag = 1'b1;
				set_valid = 1'b1;
				clear_dirty = 1'b1;
				state_d = dc_lookup; // replays as a hit.
			end
		end
		default: state_d = dc_idle;
	endcase
end

endmodule : dcache_control

/* icache/icache.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module icache
	import rv32i_types_pkg::*, cache_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic instr_read,
	input rv32i_addr instr_addr,
	input cache_line ic_pmem_rdata,
	input logic ic_pmem_resp,
	output rv32i_word instr_rdata,
	output logic instr_resp,
	output logic ic_pmem_read,
	output rv32i_addr ic_pmem_addr
);

cache_line data_arr [`CACHE_SETS];
cache_tag tag_arr [`CACHE_SETS];
logic [`CACHE_SETS-1:0] valid_arr;

icache_state state_q;
icache_state state_d;
rv32i_addr stage_addr;
logic stage_read;
logic load_stage;
logic fill_done;
logic hit;

cache_index idx;
cache_tag stage_tag;
word_offset offset;
cache_line hit_line;

assign idx = stage_addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
assign stage_tag = stage_addr[31 -: `CACHE_TAG_BITS];
assign offset = stage_addr[`CACHE_OFFSET_BITS-1:2];

assign hit = stage_read && valid_arr[idx] && (tag_arr[idx] == stage_tag);
assign hit_line = data_arr[idx];
assign instr_rdata = hit_line[32*offset +: 32];
assign ic_pmem_addr = {stage_tag, idx, {`CACHE_OFFSET_BITS{1'b0}}};

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state_q <= ic_idle;
		stage_read <= 1'b0;
		valid_arr <= '0;
	end else begin
		state_q <= state_d;
		if (load_stage) begin
			stage_read <= instr_read;
		end
		if (fill_done) begin
			valid_arr[idx] <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (load_stage) begin
		stage_addr <= instr_addr;
	end
	if (fill_done) begin
		data_arr[idx] <= ic_pmem_rdata;
		tag_arr[idx] <= stage_tag;
	end
end

always_comb begin
	state_d = state_q;
	load_stage = 1'b0;
	fill_done = 1'b0;
	instr_resp = 1'b0;
	ic_pmem_read = 1'b0;
	unique case (state_q)
		ic_idle: begin
			if (instr_read) begin
				load_stage = 1'b1;
				state_d = ic_lookup;
			end
		end
		ic_lookup: begin
			if (hit) begin
				instr_resp = 1'b1;
				load_stage = 1'b1;
				state_d = instr_read ? ic_lookup : ic_idle;
			end else begin
				state_d = ic_fill;
			end
		end
		ic_fill: begin
			ic_pmem_read = 1'b1;
			if (ic_pmem_resp) begin
				fill_done = 1'b1;
				state_d = ic_lookup;
			end
		end
		default: state_d = ic_idle;
	endcase
end

endmodule : icache

/* hw/pmem_arbiter.sv */
`timescale 1ns/1ns

module pmem_arbiter
	import rv32i_types_pkg::*, cache_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic dc_pmem_read,
	input logic dc_pmem_write,
	input rv32i_addr dc_pmem_addr,
	input cache_line dc_pmem_wdata,
	output logic dc_pmem_resp,
	output cache_line dc_pmem_rdata,
	input logic ic_pmem_read,
	input rv32i_addr ic_pmem_addr,
	output logic ic_pmem_resp,
	output cache_line ic_pmem_rdata,
	input cache_line pmem_rdata,
	input logic pmem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_addr pmem_addr,
	output cache_line pmem_wdata
);

logic busy;
logic owner; // 1 is the icache.
logic last_owner;
logic dc_req;
logic ic_req;
logic grant;

assign dc_req = dc_pmem_read || dc_pmem_write;
assign ic_req = ic_pmem_read;

always_comb begin
	if (busy) begin
		grant = owner;
	end else if (dc_req && ic_req) begin
		grant = ~last_owner; // the one not served last.
	end else begin
		grant = ic_req;
	end
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		busy <= 1'b0;
		owner <= 1'b0;
		last_owner <= 1'b1;
	end else if (pmem_resp) begin
		busy <= 1'b0;
		last_owner <= grant;
	end else if (!busy && (dc_req || ic_req)) begin
		busy <= 1'b1;
		owner <= grant;
	end
end

assign pmem_read = grant ? ic_pmem_read : dc_pmem_read;
assign pmem_write = !grant && dc_pmem_write;
assign pmem_addr = grant ? ic_pmem_addr : dc_pmem_addr;
assign pmem_wdata = dc_pmem_wdata;

assign dc_pmem_resp = pmem_resp && !grant;
assign ic_pmem_resp = pmem_resp && grant;
assign dc_pmem_rdata = pmem_rdata;
assign ic_pmem_rdata = pmem_rdata;

endmodule : pmem_arbiter

/* hw/cache_hierarchy.sv */
`timescale 1ns/1ns

module cache_hierarchy
	import rv32i_types_pkg::*, cache_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic data_read,
	input logic data_write,
	input rv32i_addr data_addr,
	input rv32i_word data_wdata,
	input byte_mask data_byte_enable,
	output rv32i_word data_rdata,
	output logic data_resp,
	input logic instr_read,
	input rv32i_addr instr_addr,
	output rv32i_word instr_rdata,
	output logic instr_resp,
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_addr pmem_addr,
	output cache_line pmem_wdata,
	input cache_line pmem_rdata,
	input logic pmem_resp
);

logic load_stage;
logic load_data;
logic load_tag;
logic set_valid;
logic set_dirty;
logic clear_dirty;
logic load_lru;
logic addr_sel_way;
logic hit;
logic hit_way;
logic lru_way;
logic victim_dirty;

logic dc_pmem_read;
logic dc_pmem_write;
rv32i_addr dc_pmem_addr;
cache_line dc_pmem_wdata;
cache_line dc_pmem_rdata;
logic dc_pmem_resp;

logic ic_pmem_read;
rv32i_addr ic_pmem_addr;
cache_line ic_pmem_rdata;
logic ic_pmem_resp;

dcache_datapath dcache_datapath_inst (
	.clk(clk),
	.arst_n(arst_n),
	.data_addr(data_addr),
	.data_wdata(data_wdata),
	.data_byte_enable(data_byte_enable),
	.data_read(data_read),
	.data_write(data_write),
	.load_stage(load_stage),
	.load_data(load_data),
	.load_tag(load_tag),
	.set_valid(set_valid),
	.set_dirty(set_dirty),
	.clear_dirty(clear_dirty),
	.load_lru(load_lru),
	.addr_sel_way(addr_sel_way),
	.dc_pmem_rdata(dc_pmem_rdata),
	.data_rdata(data_rdata),
	.hit(hit),
	.hit_way(hit_way),
	.lru_way(lru_way),
	.victim_dirty(victim_dirty),
	.dc_pmem_addr(dc_pmem_addr),
	.dc_pmem_wdata(dc_pmem_wdata)
);

dcache_control dcache_control_inst (
	.clk(clk),
	.arst_n(arst_n),
	.data_read(data_read),
	.data_write(data_write),
	.hit(hit),
	.hit_way(hit_way),
	.lru_way(lru_way),
	.victim_dirty(victim_dirty),
	.dc_pmem_resp(dc_pmem_resp),
	.data_resp(data_resp),
	.load_stage(load_stage),
	.load_data(load_data),
	.load_tag(load_tag),
	.set_valid(set_valid),
	.set_dirty(set_dirty),
	.clear_dirty(clear_dirty),
	.load_lru(load_lru),
	.addr_sel_way(addr_sel_way),
	.dc_pmem_read(dc_pmem_read),
	.dc_pmem_write(dc_pmem_write)
);

icache icache_inst (
	.clk(clk),
	.arst_n(arst_n),
	.instr_read(instr_read),
	.instr_addr(instr_addr),
	.ic_pmem_rdata(ic_pmem_rdata),
	.ic_pmem_resp(ic_pmem_resp),
	.instr_rdata(instr_rdata),
	.instr_resp(instr_resp),
	.ic_pmem_read(ic_pmem_read),
	.ic_pmem_addr(ic_pmem_addr)
);

pmem_arbiter pmem_arbiter_inst (
	.clk(clk),
	.arst_n(arst_n),
	.dc_pmem_read(dc_pmem_read),
	.dc_pmem_write(dc_pmem_write),
	.dc_pmem_addr(dc_pmem_addr),
	.dc_pmem_wdata(dc_pmem_wdata),
	.dc_pmem_resp(dc_pmem_resp),
	.dc_pmem_rdata(dc_pmem_rdata),
	.ic_pmem_read(ic_pmem_read),
	.ic_pmem_addr(ic_pmem_addr),
	.ic_pmem_resp(ic_pmem_resp),
	.ic_pmem_rdata(ic_pmem_rdata),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_addr(pmem_addr),
	.pmem_wdata(pmem_wdata)
);

endmodule : cache_hierarchy

/* testbench/pmem_model.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module pmem_model
	import rv32i_types_pkg::*, cache_types_pkg::*;
#(
	parameter int resp_delay = 3, // cycles from request to resp.
	parameter int num_lines = 256
) (
	input logic clk,
	input logic arst_n,
	input logic pmem_read,
	input logic pmem_write,
	input rv32i_addr pmem_addr,
	input cache_line pmem_wdata,
	output cache_line pmem_rdata,
	output logic pmem_resp
);

localparam int line_bits = $clog2(num_lines);

cache_line mem [num_lines]; // loaded by the testbench at time zero.
logic [7:0] wait_count;
logic [line_bits-1:0] line_idx;
logic fire;

assign line_idx = pmem_addr[`CACHE_OFFSET_BITS +: line_bits]; // upper bits wrap.
assign fire = (pmem_read || pmem_write) && !pmem_resp &&
	(wait_count == 8'(resp_delay - 1));

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		pmem_resp <= 1'b0;
		pmem_rdata <= '0;
		wait_count <= '0;
	end else begin
		pmem_resp <= fire; // one-cycle pulse.
		if (fire && pmem_read) begin
			pmem_rdata <= mem[line_idx];
		end
		if (fire || pmem_resp || !(pmem_read || pmem_write)) begin
			wait_count <= '0;
		end else begin
			wait_count <= wait_count + 8'd1;
		end
	end
end

always @(posedge clk) begin
	if (fire && pmem_write) begin
		mem[line_idx] <= pmem_wdata;
	end
end

endmodule : pmem_model

/* testbench/cache_hierarchy_tb.sv */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_hierarchy_tb
	import rv32i_types_pkg::*, cache_types_pkg::*;
();

localparam int num_ops = 27;
localparam int shadow_words = 2048;
localparam int mem_lines = 256;
localparam int mem_delay = 3;
localparam int resp_timeout = 200;
localparam int expected_writebacks = 3;
localparam rv32i_word lcg_seed = 32'h16a2_3e9c;

typedef struct packed {
	logic instr; // instruction port, else data port.
	logic write;
	logic together; // issued in the same cycle as the next row.
	logic quiet; // must hit with no memory traffic.
	rv32i_addr addr;
	rv32i_word wdata;
	byte_mask be;
} op_row;

// instr, write, together, quiet, address, write data, byte enables.
localparam op_row ops [num_ops] = '{
	'{1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0004, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0038, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_005c, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0060, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_0044, 32'ha5a5_1234, 4'b0110},
	'{1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0044, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_0128, 32'h0bad_f00d, 4'b1001},
	'{1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0128, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_0140, 32'h1357_9bdf, 4'b1111},
	'{1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0248, 32'h0000_0000, 4'h0}, // evicts dirty 0x40.
	'{1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0044, 32'h0000_0000, 4'h0}, // evicts dirty 0x140.
	'{1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0364, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0068, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0470, 32'h0000_0000, 4'h0}, // lru victim is 0x360.
	'{1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_007c, 32'h0000_0000, 4'h0},
	'{1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_0044, 32'h0000_0000, 4'h0},
	'{1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_0400, 32'h0000_0000, 4'h0},
	'{1'b1, 1'b0, 1'b0, 1'b1, 32'h0000_0408, 32'h0000_0000, 4'h0},
	'{1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_0140, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b0, 1'b1, 1'b0, 32'h0000_0580, 32'h0000_0000, 4'h0},
	'{1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_06a0, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b1, 1'b1, 1'b0, 32'h0000_0230, 32'hcafe_0001, 4'b1111},
	'{1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_0784, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b0, 1'b1, 1'b0, 32'h0000_0324, 32'h0000_0000, 4'h0}, // evicts dirty 0x120.
	'{1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_0604, 32'h0000_0000, 4'h0},
	'{1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_0128, 32'h0000_0000, 4'h0},
	'{1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0230, 32'h0000_0000, 4'h0}
};

logic clk;
logic arst_n;
logic data_read;
logic data_write;
rv32i_addr data_addr;
rv32i_word data_wdata;
byte_mask data_byte_enable;
rv32i_word data_rdata;
logic data_resp;
logic instr_read;
rv32i_addr instr_addr;
rv32i_word instr_rdata;
logic instr_resp;
logic pmem_read;
logic pmem_write;
rv32i_addr pmem_addr;
cache_line pmem_wdata;
cache_line pmem_rdata;
logic pmem_resp;

rv32i_word shadow [shadow_words]; // expected memory image, one entry per word.
logic in_flight = 1'b0;
logic xfer_write = 1'b0;
rv32i_addr xfer_addr = '0;
int wb_count = 0;

cache_hierarchy cache_hierarchy_inst (
	.clk(clk),
	.arst_n(arst_n),
	.data_read(data_read),
	.data_write(data_write),
	.data_addr(data_addr),
	.data_wdata(data_wdata),
	.data_byte_enable(data_byte_enable),
	.data_rdata(data_rdata),
	.data_resp(data_resp),
	.instr_read(instr_read),
	.instr_addr(instr_addr),
	.instr_rdata(instr_rdata),
	.instr_resp(instr_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_addr(pmem_addr),
	.pmem_wdata(pmem_wdata),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp)
);

pmem_model #(
	.resp_delay(mem_delay),
	.num_lines(mem_lines)
) pmem_model_inst (
	.clk(clk),
	.arst_n(arst_n),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_addr(pmem_addr),
	.pmem_wdata(pmem_wdata),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp)
);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

function automatic rv32i_word lcg_next(input rv32i_word state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic cache_line shadow_line(input rv32i_addr addr);
	cache_line line;
	for (int w = 0; w < 8; w++) begin
		line[32*w +: 32] = shadow[{addr[12:5], 3'(w)}];
	end
	return line;
endfunction

task automatic abort_run();
	$display("Simulation FAILED");
	$fatal(1, "run stopped");
endtask

task automatic report_failure(input string reason);
	$display("%s", reason);
	abort_run();
endtask

task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
	if (got !== exp) begin
		$display("error: time %0t, %s got %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_line(input string name, input cache_line got, input cache_line exp);
	if (got !== exp) begin
		$display("error: time %0t, %s got %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("error: time %0t, %s got %b, expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic complete_data_op(input int r);
	int w;
	w = int'(ops[r].addr[12:2]);
	if (ops[r].write) begin
		for (int k = 0; k < 4; k++) begin
			if (ops[r].be[k]) begin
				shadow[w][8*k +: 8] = ops[r].wdata[8*k +: 8];
			end
		end
	end else begin
		check_word("data_rdata", data_rdata, shadow[w]);
	end
	data_read = 1'b0;
	data_write = 1'b0;
endtask

// issues n rows in one cycle and waits for every resp.
task automatic run_ops(input int first, input int n);
	logic d_busy;
	logic i_busy;
	logic quiet;
	int d_row;
	int i_row;
	int cycles;
	d_busy = 1'b0;
	i_busy = 1'b0;
	quiet = 1'b0;
	d_row = 0;
	i_row = 0;
	cycles = 0;
	@(negedge clk);
	for (int k = first; k < first + n; k++) begin
		if (ops[k].instr) begin
			instr_read = 1'b1;
			instr_addr = ops[k].addr;
			i_busy = 1'b1;
			i_row = k;
		end else begin
			data_read = !ops[k].write;
			data_write = ops[k].write;
			data_addr = ops[k].addr;
			data_wdata = ops[k].wdata;
			data_byte_enable = ops[k].be;
			d_busy = 1'b1;
			d_row = k;
		end
		quiet = quiet | ops[k].quiet;
	end
	while (d_busy || i_busy) begin
		@(negedge clk);
		cycles++;
		if (cycles > resp_timeout) begin
			report_failure($sformatf("row %0d got no resp within %0d cycles", first, resp_timeout));
		end else if (quiet && (pmem_read || pmem_write)) begin
			report_failure($sformatf("row %0d should hit but went to memory", first));
		end
		if (d_busy && data_resp) begin
			complete_data_op(d_row);
			d_busy = 1'b0;
		end
		if (i_busy && instr_resp) begin
			check_word("instr_rdata", instr_rdata, shadow[ops[i_row].addr[12:2]]);
			instr_read = 1'b0;
			i_busy = 1'b0;
		end
	end
endtask

// memory bus watcher, one transaction at a time.
always @(negedge clk) begin
	if (arst_n) begin
		if (pmem_read && pmem_write) begin
			report_failure("memory read and write were issued in the same cycle");
		end else if (in_flight) begin
			if (!(pmem_read || pmem_write) || pmem_write != xfer_write || pmem_addr != xfer_addr) begin
				report_failure("memory request changed before its pmem_resp");
			end else if (pmem_resp) begin
				if (xfer_write) begin
					wb_count++;
					check_line($sformatf("memory line %h", xfer_addr),
						pmem_model_inst.mem[xfer_addr[12:5]], shadow_line(xfer_addr));
				end
				in_flight = 1'b0;
			end
		end else if (pmem_read || pmem_write) begin
			if (pmem_addr[4:0] != 5'b0) begin
				report_failure("memory address is not line-aligned");
			end
			in_flight = 1'b1;
			xfer_write = pmem_write;
			xfer_addr = pmem_addr;
		end
	end
end

initial begin
	rv32i_word lcg_state;
	int row;
	arst_n = 1'b0;
	data_read = 1'b0;
	data_write = 1'b0;
	data_addr = '0;
	data_wdata = '0;
	data_byte_enable = '0;
	instr_read = 1'b0;
	instr_addr = '0;
	lcg_state = lcg_seed;
	for (int i = 0; i < shadow_words; i++) begin
		lcg_state = lcg_next(lcg_state);
		shadow[i] = lcg_state ^ (32'(i) << 2); // mix in the byte address.
	end
	for (int l = 0; l < mem_lines; l++) begin
		pmem_model_inst.mem[l] = shadow_line(rv32i_addr'(l) << `CACHE_OFFSET_BITS);
	end
	repeat (5) @(posedge clk);
	@(negedge clk);
	arst_n = 1'b1;
	check_flag("data_resp", data_resp, 1'b0);
	check_flag("instr_resp", instr_resp, 1'b0);
	check_flag("pmem_read", pmem_read, 1'b0);
	check_flag("pmem_write", pmem_write, 1'b0);
	row = 0;
	while (row < num_ops) begin
		if (ops[row].together) begin
			run_ops(row, 2);
			row += 2;
		end else begin
			run_ops(row, 1);
			row += 1;
		end
	end
	@(negedge clk);
	if (wb_count != expected_writebacks) begin
		report_failure($sformatf("saw %0d dirty writebacks instead of %0d",
			wb_count, expected_writebacks));
	end else begin
		$display("Simulation PASSED");
		$finish;
	end
end

endmodule : cache_hierarchy_tb

/* cache_hierarchy.f */
+incdir+common
common/rv32i_types_pkg.sv
common/cache_types_pkg.sv
dcache/dcache_datapath.sv
dcache/dcache_control.sv
icache/icache.sv
hw/pmem_arbiter.sv
hw/cache_hierarchy.sv
testbench/pmem_model.sv
testbench/cache_hierarchy_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cache_hierarchy_tb
FILELIST ?= cache_hierarchy.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ns -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
